/* source/vr_config.svh */
`ifndef VR_CONFIG_SVH
`define VR_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define VR_VIEW_W       8
`define VR_OP_W         16
`define VR_CLIENT_W     16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// log geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define VR_LOG_DEPTH    16
`define VR_LOG_ADDR_W   4   // slot is the low bits of the op number.

`endif

/* source/vr_pkg.sv */
`include "vr_config.svh"

package vr_pkg;

    typedef enum logic [1:0] {
        MSG_PREPARE   = 2'd0,
        MSG_COMMIT    = 2'd1,
        MSG_LOG_QUERY = 2'd2
    } vr_msg_type_e;    // 2'd3 is unknown and dropped.

    typedef enum logic [2:0] {
        RESP_PREPARE_OK   = 3'd0,
        RESP_PREPARE_NACK = 3'd1,
        RESP_COMMIT_ACK   = 3'd2,
        RESP_COMMIT_NACK  = 3'd3,
        RESP_LOG_ENTRY    = 3'd4
    } vr_resp_type_e;

    typedef struct packed {
        vr_msg_type_e               msg_type;
        logic [`VR_VIEW_W-1:0]      view;
        logic [`VR_OP_W-1:0]        op_num;     // commit target or queried op.
        logic [`VR_CLIENT_W-1:0]    client_id;
    } vr_msg_t;

    typedef struct packed {
        vr_resp_type_e              resp_type;
        logic [`VR_VIEW_W-1:0]      view;
        logic [`VR_OP_W-1:0]        op_num;
        logic [`VR_CLIENT_W-1:0]    client_id;
        logic                       committed;
    } vr_resp_t;

    typedef struct packed {
        logic [`VR_VIEW_W-1:0]      view;
        logic [`VR_OP_W-1:0]        last_op;
        logic [`VR_OP_W-1:0]        commit_num;
    } vr_state_t;

    typedef struct packed {
        logic [`VR_VIEW_W-1:0]      view;
        logic [`VR_CLIENT_W-1:0]    client_id;
        logic                       committed;
    } log_hdr_t;

    typedef struct packed {
        logic                       wr;
        logic [`VR_LOG_ADDR_W-1:0]  addr;
        log_hdr_t                   data;
    } log_req_t;

endpackage

/* source/vr_msg_dispatch.sv */
`timescale 1ns/1ps

module vr_msg_dispatch
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       msg_val
    ,input  vr_msg_t    msg
    ,output logic       msg_rdy

    ,output logic       prep_val
    ,output logic       commit_val
    ,output vr_msg_t    fwd_msg
    ,input  logic       prep_idle
    ,input  logic       commit_idle
);

    logic       buf_val;
    vr_msg_t    buf_msg;
    logic       fwd;

    assign msg_rdy = ~buf_val;
    assign fwd_msg = buf_msg;

    // one engine busy at a time keeps a single writer on the state.
    assign fwd = buf_val & prep_idle & commit_idle;

    always_comb begin
        prep_val = 1'b0;
        commit_val = 1'b0;
        case (buf_msg.msg_type)
            MSG_PREPARE:   prep_val = fwd;
            MSG_COMMIT,
            MSG_LOG_QUERY: commit_val = fwd;
            default:       ;    // unknown types are freed silently.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_val <= 1'b0;
        end else if (msg_val && msg_rdy) begin
            buf_val <= 1'b1;
        end else if (fwd) begin
            buf_val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (msg_val && msg_rdy) begin
            buf_msg <= msg;
        end
    end

endmodule

/* source/prepare_eng.sv */
`timescale 1ns/1ps
`include "vr_config.svh"

module prepare_eng
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       msg_val
    ,input  vr_msg_t    msg
    ,output logic       idle

    ,input  vr_state_t  state
    ,output logic       last_op_wr

    ,output logic       log_req_val
    ,output log_req_t   log_req
    ,input  logic       log_req_rdy

    ,output logic       resp_val
    ,output vr_resp_t   resp
    ,input  logic       resp_rdy
);

    typedef enum logic [1:0] {IDLE, WRITE, REPLY} prep_state_e;

    prep_state_e            st_q;
    prep_state_e            st_next;
    logic                   accept;
    logic                   ok;
    logic [`VR_OP_W-1:0]    span;
    log_req_t               req_q;
    vr_resp_t               resp_q;

    assign idle = (st_q == IDLE);
    assign accept = idle & msg_val;

    // window check keeps uncommitted ops from wrapping onto live slots.
    assign span = msg.op_num - state.commit_num;
    assign ok = (msg.view == state.view)
             && (msg.op_num == state.last_op + 1'b1)
             && (span <= `VR_OP_W'(`VR_LOG_DEPTH));

    assign last_op_wr = accept & ok;    // state moves at acceptance.
    assign log_req_val = (st_q == WRITE);
    assign log_req = req_q;
    assign resp_val = (st_q == REPLY);
    assign resp = resp_q;

    always_comb begin
        st_next = st_q;
        case (st_q)
            IDLE:  if (accept) st_next = ok ? WRITE : REPLY;
            WRITE: if (log_req_rdy) st_next = REPLY;
            REPLY: if (resp_rdy) st_next = IDLE;
            default: st_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_q <= IDLE;
        end else begin
            st_q <= st_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.wr <= 1'b1;
            req_q.addr <= msg.op_num[`VR_LOG_ADDR_W-1:0];
            req_q.data <= '{view: msg.view, client_id: msg.client_id, committed: 1'b0};
            resp_q.resp_type <= ok ? RESP_PREPARE_OK : RESP_PREPARE_NACK;
            resp_q.view <= state.view;
            resp_q.op_num <= ok ? msg.op_num : state.last_op;    // nack reports last op.
            resp_q.client_id <= msg.client_id;
            resp_q.committed <= 1'b0;
        end
    end

endmodule

/* source/commit_eng.sv */
`timescale 1ns/1ps
`include "vr_config.svh"

module commit_eng
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       msg_val
    ,input  vr_msg_t    msg
    ,output logic       idle

    ,input  vr_state_t  state
    ,output logic       commit_wr

    ,output logic       log_req_val
    ,output log_req_t   log_req
    ,input  logic       log_req_rdy

    ,input  logic       rd_resp_val
    ,input  log_hdr_t   rd_resp

    ,output logic       resp_val
    ,output vr_resp_t   resp
    ,input  logic       resp_rdy
);

    typedef enum logic [2:0] {IDLE, READ, WAIT, WRITE, REPLY} commit_state_e;

    commit_state_e          st_q;
    commit_state_e          st_next;
    logic                   accept;
    logic                   is_query;
    logic                   cmt_ok;
    logic                   query_q;
    logic [`VR_OP_W-1:0]    cur_q;
    logic [`VR_OP_W-1:0]    tgt_q;
    log_hdr_t               hdr_q;
    vr_resp_t               resp_q;

    assign idle = (st_q == IDLE);
    assign accept = idle & msg_val;
    assign is_query = (msg.msg_type == MSG_LOG_QUERY);
    assign cmt_ok = (msg.view == state.view)
                 && (msg.op_num > state.commit_num)
                 && (msg.op_num <= state.last_op);

    // commit number moves up front; nothing else is forwarded until the walk ends.
    assign commit_wr = accept & ~is_query & cmt_ok;

    assign log_req_val = (st_q == READ) || (st_q == WRITE);
    assign resp_val = (st_q == REPLY);
    assign resp = resp_q;

    always_comb begin
        log_req.wr = (st_q == WRITE);
        log_req.addr = cur_q[`VR_LOG_ADDR_W-1:0];
        log_req.data = hdr_q;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read-modify-write walk over the log headers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        st_next = st_q;
        case (st_q)
            IDLE:  if (accept) st_next = (is_query || cmt_ok) ? READ : REPLY;
            READ:  if (log_req_rdy) st_next = WAIT;
            WAIT:  if (rd_resp_val) st_next = query_q ? REPLY : WRITE;
            WRITE: if (log_req_rdy) st_next = (cur_q == tgt_q) ? REPLY : READ;
            REPLY: if (resp_rdy) st_next = IDLE;
            default: st_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_q <= IDLE;
        end else begin
            st_q <= st_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            query_q <= is_query;
            cur_q <= is_query ? msg.op_num : state.commit_num + 1'b1;
            tgt_q <= msg.op_num;
            resp_q.resp_type <= is_query ? RESP_LOG_ENTRY :
                                cmt_ok   ? RESP_COMMIT_ACK : RESP_COMMIT_NACK;
            resp_q.view <= state.view;
            resp_q.op_num <= (is_query || cmt_ok) ? msg.op_num : state.commit_num;
            resp_q.client_id <= '0;
            resp_q.committed <= 1'b0;
        end
        if (st_q == WAIT && rd_resp_val) begin
            hdr_q <= '{view: rd_resp.view, client_id: rd_resp.client_id, committed: 1'b1};
            if (query_q) begin
                resp_q.view <= rd_resp.view;    // query echoes the stored header.
                resp_q.client_id <= rd_resp.client_id;
                resp_q.committed <= rd_resp.committed;
            end
        end
        if (st_q == WRITE && log_req_rdy) begin
            cur_q <= cur_q + 1'b1;
        end
    end

endmodule

/* source/log_hdr_arbiter.sv */
`timescale 1ns/1ps

module log_hdr_arbiter
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       prep_req_val
    ,input  log_req_t   prep_req
    ,output logic       prep_req_rdy

    ,input  logic       commit_req_val
    ,input  log_req_t   commit_req
    ,output logic       commit_req_rdy

    ,output logic       mem_req_val
    ,output log_req_t   mem_req

    ,input  logic       rd_resp_val
    ,input  log_hdr_t   rd_resp
    ,output logic       commit_rd_resp_val
    ,output log_hdr_t   commit_rd_resp
);

    logic   prio_commit;    // round-robin pointer.
    logic   gnt_prep;
    logic   gnt_commit;
    logic   rd_pend_commit;

    assign gnt_prep = prep_req_val & (~commit_req_val | ~prio_commit);
    assign gnt_commit = commit_req_val & ~gnt_prep;

    assign prep_req_rdy = gnt_prep;
    assign commit_req_rdy = gnt_commit;
    assign mem_req_val = gnt_prep | gnt_commit;
    assign mem_req = gnt_commit ? commit_req : prep_req;

    // only commit reads, so the response goes back to it alone.
    assign commit_rd_resp_val = rd_resp_val & rd_pend_commit;
    assign commit_rd_resp = rd_resp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_commit <= 1'b0;
            rd_pend_commit <= 1'b0;
        end else begin
            if (mem_req_val) prio_commit <= gnt_prep;
            rd_pend_commit <= gnt_commit & ~commit_req.wr;
        end
    end

endmodule

/* source/log_hdr_mem.sv */
`timescale 1ns/1ps
`include "vr_config.svh"

module log_hdr_mem
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       req_val
    ,input  log_req_t   req
    ,output logic       rd_resp_val
    ,output log_hdr_t   rd_resp
);

    log_hdr_t   mem [`VR_LOG_DEPTH];

    always_ff @(posedge clk) begin
        if (req_val) begin
            if (req.wr) begin
                mem[req.addr] <= req.data;
            end else begin
                rd_resp <= mem[req.addr];   // data one cycle after grant.
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_resp_val <= 1'b0;
        end else begin
            rd_resp_val <= req_val & ~req.wr;
        end
    end

endmodule

/* source/resp_merger.sv */
`timescale 1ns/1ps

module resp_merger
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       prep_val
    ,input  vr_resp_t   prep_resp
    ,output logic       prep_rdy

    ,input  logic       commit_val
    ,input  vr_resp_t   commit_resp
    ,output logic       commit_rdy

    ,output logic       resp_val
    ,output vr_resp_t   resp
    ,input  logic       resp_rdy
);

    logic       out_val;
    vr_resp_t   out_q;
    logic       take;
    logic       sel_commit;
    logic       last_commit;

    assign take = ~out_val | resp_rdy;  // empty or draining.
    assign sel_commit = commit_val & (~prep_val | ~last_commit);
    assign prep_rdy = take & prep_val & ~sel_commit;
    assign commit_rdy = take & sel_commit;
    assign resp_val = out_val;
    assign resp = out_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_val <= 1'b0;
            last_commit <= 1'b0;
        end else if (take) begin
            out_val <= prep_val | commit_val;
            if (prep_val || commit_val) last_commit <= sel_commit;
        end
    end

    always_ff @(posedge clk) begin
        if (prep_rdy || commit_rdy) begin
            out_q <= sel_commit ? commit_resp : prep_resp;
        end
    end

endmodule

/* source/vr_core.sv */
`timescale 1ns/1ps

module vr_core
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       msg_val
    ,input  vr_msg_t    msg
    ,output logic       msg_rdy

    ,output logic       resp_val
    ,output vr_resp_t   resp
    ,input  logic       resp_rdy
);

    vr_state_t  vr_state_q;

    logic       prep_val;
    logic       commit_val;
    vr_msg_t    fwd_msg;
    logic       prep_idle;
    logic       commit_idle;
    logic       last_op_wr;
    logic       commit_wr;

    logic       prep_req_val;
    log_req_t   prep_req;
    logic       prep_req_rdy;
    logic       commit_req_val;
    log_req_t   commit_req;
    logic       commit_req_rdy;
    logic       mem_req_val;
    log_req_t   mem_req;
    logic       rd_resp_val;
    log_hdr_t   rd_resp;
    logic       commit_rd_resp_val;
    log_hdr_t   commit_rd_resp;

    logic       prep_resp_val;
    vr_resp_t   prep_resp;
    logic       prep_resp_rdy;
    logic       commit_resp_val;
    vr_resp_t   commit_resp;
    logic       commit_resp_rdy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // replica state. view has no writer and stays 0.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vr_state_q <= '0;
        end else begin
            if (last_op_wr) vr_state_q.last_op <= fwd_msg.op_num;
            if (commit_wr) vr_state_q.commit_num <= fwd_msg.op_num;
        end
    end

    vr_msg_dispatch dispatch_inst (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.msg_val       (msg_val        )
        ,.msg           (msg            )
        ,.msg_rdy       (msg_rdy        )
        ,.prep_val      (prep_val       )
        ,.commit_val    (commit_val     )
        ,.fwd_msg       (fwd_msg        )
        ,.prep_idle     (prep_idle      )
        ,.commit_idle   (commit_idle    )
    );

    prepare_eng prep_eng_inst (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.msg_val       (prep_val       )
        ,.msg           (fwd_msg        )
        ,.idle          (prep_idle      )
        ,.state         (vr_state_q     )
        ,.last_op_wr    (last_op_wr     )
        ,.log_req_val   (prep_req_val   )
        ,.log_req       (prep_req       )
        ,.log_req_rdy   (prep_req_rdy   )
        ,.resp_val      (prep_resp_val  )
        ,.resp          (prep_resp      )
        ,.resp_rdy      (prep_resp_rdy  )
    );

    commit_eng commit_eng_inst (
         .clk           (clk                )
        ,.rst_n         (rst_n              )
        ,.msg_val       (commit_val         )
        ,.msg           (fwd_msg            )
        ,.idle          (commit_idle        )
        ,.state         (vr_state_q         )
        ,.commit_wr     (commit_wr          )
        ,.log_req_val   (commit_req_val     )
        ,.log_req       (commit_req         )
        ,.log_req_rdy   (commit_req_rdy     )
        ,.rd_resp_val   (commit_rd_resp_val )
        ,.rd_resp       (commit_rd_resp     )
        ,.resp_val      (commit_resp_val    )
        ,.resp          (commit_resp        )
        ,.resp_rdy      (commit_resp_rdy    )
    );

    log_hdr_arbiter arbiter_inst (
         .clk                   (clk                )
        ,.rst_n                 (rst_n              )
        ,.prep_req_val          (prep_req_val       )
        ,.prep_req              (prep_req           )
        ,.prep_req_rdy          (prep_req_rdy       )
        ,.commit_req_val        (commit_req_val     )
        ,.commit_req            (commit_req         )
        ,.commit_req_rdy        (commit_req_rdy     )
        ,.mem_req_val           (mem_req_val        )
        ,.mem_req               (mem_req            )
        ,.rd_resp_val           (rd_resp_val        )
        ,.rd_resp               (rd_resp            )
        ,.commit_rd_resp_val    (commit_rd_resp_val )
        ,.commit_rd_resp        (commit_rd_resp     )
    );

    log_hdr_mem log_mem_inst (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.req_val       (mem_req_val    )
        ,.req           (mem_req        )
        ,.rd_resp_val   (rd_resp_val    )
        ,.rd_resp       (rd_resp        )
    );

    resp_merger merger_inst (
         .clk           (clk                )
        ,.rst_n         (rst_n              )
        ,.prep_val      (prep_resp_val      )
        ,.prep_resp     (prep_resp          )
        ,.prep_rdy      (prep_resp_rdy      )
        ,.commit_val    (commit_resp_val    )
        ,.commit_resp   (commit_resp        )
        ,.commit_rdy    (commit_resp_rdy    )
        ,.resp_val      (resp_val           )
        ,.resp          (resp               )
        ,.resp_rdy      (resp_rdy           )
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
     output logic   clk
    ,output logic   rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verification/vr_core_assertions.sv */
`timescale 1ns/1ps

module vr_core_assertions
import vr_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n
    ,input  logic       msg_val
    ,input  logic       msg_rdy
    ,input  logic       resp_val
    ,input  vr_resp_t   resp
    ,input  logic       resp_rdy
    ,input  vr_state_t  vr_state_q
    ,input  logic       prep_req_val
    ,input  logic       commit_req_val
);

    // a stalled reply holds still until taken.
    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_val && !resp_rdy |=> resp_val && $stable(resp))
        else $error("reply changed or dropped while stalled");

    commit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        vr_state_q.commit_num <= vr_state_q.last_op)
        else $error("commit number ran past last op");

    // only one engine is busy at a time, so the log memory sees one requester.
    one_requester: assert property (@(posedge clk) disable iff (!rst_n)
        !(prep_req_val && commit_req_val))
        else $error("both engines requested the log memory at once");

    buf_full: assert property (@(posedge clk) disable iff (!rst_n)
        msg_val && msg_rdy |=> !msg_rdy)   // buffer holds the message now.
        else $error("msg_rdy high with a message buffered");

endmodule

bind vr_core vr_core_assertions assertions_inst (
     .clk               (clk            )
    ,.rst_n             (rst_n          )
    ,.msg_val           (msg_val        )
    ,.msg_rdy           (msg_rdy        )
    ,.resp_val          (resp_val       )
    ,.resp              (resp           )
    ,.resp_rdy          (resp_rdy       )
    ,.vr_state_q        (vr_state_q     )
    ,.prep_req_val      (prep_req_val   )
    ,.commit_req_val    (commit_req_val )
);

/* verification/vr_core_tb.sv */
`timescale 1ns/1ps
`include "vr_config.svh"

module vr_core_tb
import vr_pkg::*;
();

    // about 35 messages of at most ~100 cycles each under back-pressure.
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clk;
    logic       rst_n;
    logic       msg_val;
    vr_msg_t    msg;
    logic       msg_rdy;
    logic       resp_val;
    vr_resp_t   resp;
    logic       resp_rdy;

    int             cycles;
    int             errors;
    int             test_errors;
    int             tests_run;
    int             tests_failed;
    logic [31:0]    lcg_state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model of the replica.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [`VR_VIEW_W-1:0]  mdl_view;
    logic [`VR_OP_W-1:0]    mdl_last;
    logic [`VR_OP_W-1:0]    mdl_commit;
    log_hdr_t               mdl_log [`VR_LOG_DEPTH];
    vr_resp_t               exp_q [$];   // replies still owed in message order.

    tb_clock_gen clock_gen_inst (
         .clk       (clk    )
        ,.rst_n     (rst_n  )
    );

    vr_core vr_core_inst (
         .clk       (clk        )
        ,.rst_n     (rst_n      )
        ,.msg_val   (msg_val    )
        ,.msg       (msg        )
        ,.msg_rdy   (msg_rdy    )
        ,.resp_val  (resp_val   )
        ,.resp      (resp       )
        ,.resp_rdy  (resp_rdy   )
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a reply or handshake never came", cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic vr_msg_t make_msg(input vr_msg_type_e t,
                                         input logic [`VR_VIEW_W-1:0] v,
                                         input logic [`VR_OP_W-1:0] op,
                                         input logic [`VR_CLIENT_W-1:0] cl);
        vr_msg_t m;
        m.msg_type = t;
        m.view = v;
        m.op_num = op;
        m.client_id = cl;
        return m;
    endfunction

    // expected reply for one message; the model state moves with it.
    function automatic vr_resp_t model_reply(input vr_msg_t m);
        vr_resp_t                   r;
        logic [`VR_LOG_ADDR_W-1:0]  slot;
        logic [`VR_OP_W-1:0]        op;
        logic [`VR_OP_W-1:0]        span;
        r = '0;
        r.view = mdl_view;
        slot = m.op_num[`VR_LOG_ADDR_W-1:0];
        span = m.op_num - mdl_commit;
        case (m.msg_type)
            MSG_PREPARE: begin
                r.client_id = m.client_id;
                if (m.view == mdl_view && m.op_num == mdl_last + 16'd1
                        && span <= 16'(`VR_LOG_DEPTH)) begin
                    mdl_last = m.op_num;
                    mdl_log[slot] = '{view: m.view, client_id: m.client_id, committed: 1'b0};
                    r.resp_type = RESP_PREPARE_OK;
                    r.op_num = m.op_num;
                end else begin
                    r.resp_type = RESP_PREPARE_NACK;
                    r.op_num = mdl_last;
                end
            end
            MSG_COMMIT: begin
                if (m.view == mdl_view && m.op_num > mdl_commit && m.op_num <= mdl_last) begin
                    for (op = mdl_commit + 16'd1; op <= m.op_num; op++) begin
                        mdl_log[op[`VR_LOG_ADDR_W-1:0]].committed = 1'b1;
                    end
                    mdl_commit = m.op_num;
                    r.resp_type = RESP_COMMIT_ACK;
                    r.op_num = m.op_num;
                end else begin
                    r.resp_type = RESP_COMMIT_NACK;
                    r.op_num = mdl_commit;
                end
            end
            MSG_LOG_QUERY: begin
                r.resp_type = RESP_LOG_ENTRY;
                r.view = mdl_log[slot].view;
                r.op_num = m.op_num;
                r.client_id = mdl_log[slot].client_id;
                r.committed = mdl_log[slot].committed;
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_reply(input vr_resp_t got, input vr_resp_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED resp: got 0x%h expected 0x%h", got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic send_msg(input vr_msg_t m);
        @(posedge clk);
        msg_val <= 1'b1;
        msg <= m;
        @(negedge clk);
        while (!msg_rdy) @(negedge clk);
        @(posedge clk);     // transfer edge.
        msg_val <= 1'b0;
    endtask

    task automatic recv_reply(output vr_resp_t r);
        @(negedge clk);
        while (!resp_val) @(negedge clk);
        r = resp;
        @(posedge clk);
    endtask

    task automatic exchange(input vr_msg_t m);
        vr_resp_t exp;
        vr_resp_t got;
        exp = model_reply(m);
        send_msg(m);
        recv_reply(got);
        check_reply(got, exp);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset();
        @(negedge clk);
        if (resp_val !== 1'b0) begin
            $display("CHECK FAILED resp_val: got 0x%h expected 0x0", resp_val);
            errors++;
            test_errors++;
        end
        if (msg_rdy !== 1'b1) begin
            $display("CHECK FAILED msg_rdy: got 0x%h expected 0x1", msg_rdy);
            errors++;
            test_errors++;
        end
        finish_test("reset");
    endtask

    task automatic test_prepare_append();
        for (int op = 1; op <= 5; op++) begin
            exchange(make_msg(MSG_PREPARE, 8'd0, 16'(op), 16'hc100 + 16'(op)));
        end
        finish_test("prepare_append");
    endtask

    task automatic test_prepare_reject();
        exchange(make_msg(MSG_PREPARE, 8'd1, 16'd6, 16'hd001));    // wrong view.
        exchange(make_msg(MSG_PREPARE, 8'd0, 16'd7, 16'hd002));    // gap.
        exchange(make_msg(MSG_PREPARE, 8'd0, 16'd5, 16'hd003));
        finish_test("prepare_reject");
    endtask

    task automatic test_commit_and_query();
        exchange(make_msg(MSG_COMMIT, 8'd0, 16'd3, 16'h0));
        for (int op = 1; op <= 5; op++) begin
            exchange(make_msg(MSG_LOG_QUERY, 8'd0, 16'(op), 16'h0));
        end
        finish_test("commit_and_query");
    endtask

    task automatic test_commit_reject();
        exchange(make_msg(MSG_COMMIT, 8'd0, 16'd2, 16'h0));
        exchange(make_msg(MSG_COMMIT, 8'd0, 16'd9, 16'h0));
        exchange(make_msg(MSG_COMMIT, 8'd1, 16'd4, 16'h0));
        exchange(make_msg(MSG_COMMIT, 8'd0, 16'd5, 16'h0));
        for (int op = 1; op <= 5; op++) begin
            exchange(make_msg(MSG_LOG_QUERY, 8'd0, 16'(op), 16'h0));
        end
        finish_test("commit_reject");
    endtask

    task automatic test_backpressure();
        vr_msg_t        m;
        vr_resp_t       exp;
        logic [31:0]    rnd;
        int             n_got;
        int             i;
        n_got = 0;
        fork
            begin
                for (i = 0; i < 10; i++) begin
                    if (i % 2 == 0) begin
                        m = make_msg(MSG_PREPARE, mdl_view, mdl_last + 16'd1, 16'hb000 + 16'(i));
                    end else begin
                        m = make_msg(MSG_COMMIT, mdl_view, mdl_last, 16'h0);
                    end
                    exp_q.push_back(model_reply(m));
                    send_msg(m);
                end
            end
            begin
                while (n_got < 10) begin
                    @(posedge clk);
                    rnd = lcg_next();
                    resp_rdy <= rnd[16];
                    @(negedge clk);
                    if (resp_val && resp_rdy) begin
                        if (exp_q.size() == 0) begin
                            $display("a reply arrived with no message outstanding");
                            errors++;
                            test_errors++;
                        end else begin
                            exp = exp_q.pop_front();
                            check_reply(resp, exp);
                        end
                        n_got++;
                    end
                end
            end
        join
        @(posedge clk);
        resp_rdy <= 1'b1;
        repeat (16) begin
            @(negedge clk);
            if (resp_val) begin
                $display("an extra reply appeared after all ten were taken");
                errors++;
                test_errors++;
            end
        end
        finish_test("backpressure");
    endtask

    initial begin
        msg_val = 1'b0;
        msg = '0;
        resp_rdy = 1'b1;
        lcg_state = 32'd60141;
        cycles = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        mdl_view = '0;
        mdl_last = '0;
        mdl_commit = '0;
        for (int s = 0; s < `VR_LOG_DEPTH; s++) begin
            mdl_log[s] = '0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        test_reset();
        test_prepare_append();
        test_prepare_reject();
        test_commit_and_query();
        test_commit_reject();
        test_backpressure();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* vr_core.f */
+incdir+source
source/vr_pkg.sv
source/vr_msg_dispatch.sv
source/prepare_eng.sv
source/commit_eng.sv
source/log_hdr_arbiter.sv
source/log_hdr_mem.sv
source/resp_merger.sv
source/vr_core.sv
verification/tb_clock_gen.sv
verification/vr_core_assertions.sv
verification/vr_core_tb.sv

/* Makefile */
TOP = vr_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build vr_core with its testbench in Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vr_core.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
